// File: blocking_cache.f
logic/cache_pkg.sv
logic/req_decode.sv
logic/way_status.sv
logic/line_store.sv
logic/cache_ctrl.sv
logic/blocking_cache.sv
test/mem_model.sv
test/tb_blocking_cache.sv

// File: test/tb_blocking_cache.sv
// Testbench for the two-way blocking data cache
// Applies a table of reads and writes with random response back-pressure

`timescale 1ns/1ps

module tb_blocking_cache;
  import cache_pkg::*;

  localparam int    num_sets   = 8;
  localparam word_t fill_key   = 32'h5a3c_96e1;
  localparam int    wait_limit = 200;            // Cycles allowed in any wait loop

  typedef struct packed {
    req_type_t  req_type;
    addr_t      addr;
    word_t      wdata;
    logic       exp_hit;
    logic       chk_data;                        // Write responses carry no defined data
    word_t      exp_data;
    logic [7:0] exp_wb;                          // Line writes seen by memory so far
  } table_entry_t;

  logic        clk, reset;
  logic        req_val, req_rdy, resp_val, resp_rdy;
  logic        mem_req_val, mem_req_rdy, mem_resp_val, mem_resp_rdy;
  cache_req_t  req;
  cache_resp_t resp;
  mem_req_t    mem_req;
  mem_resp_t   mem_resp;

  table_entry_t entries[$];
  int error_count;
  int timeout_count;
  int seed;

  blocking_cache #(.num_sets(num_sets)) dut0 (.*);

  mem_model #(.num_lines(256), .delay(3), .fill_key(fill_key)) mem0 (
    .clk, .reset, .req_val(mem_req_val), .req_rdy(mem_req_rdy), .req(mem_req),
    .resp_val(mem_resp_val), .resp_rdy(mem_resp_rdy), .resp(mem_resp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                      // 100 ns period
  end

  // ==============================
  // Helpers
  // ==============================
  function automatic word_t fill_word(input addr_t a);
    return {a[31:2], 2'b00} ^ fill_key;          // Memory pattern rule
  endfunction

  task automatic add_read(input addr_t a, input logic h, input word_t d, input int wb);
    entries.push_back('{req_read, a, '0, h, 1'b1, d, wb[7:0]});
  endtask

  task automatic add_write(input addr_t a, input word_t d, input logic h, input int wb);
    entries.push_back('{req_write, a, d, h, 1'b0, '0, wb[7:0]});
  endtask

  task automatic report_error(input string msg);
    $display("[FAIL] %0d ns: %s", $time, msg);
    error_count++;
  endtask

  // One request, wait for its response, hold resp_rdy low, then take it
  task automatic run_entry(input int n, input table_entry_t e);
    int cycles;
    int latency;
    int hold;
    cache_resp_t held;
    req.req_type = e.req_type;
    req.addr     = e.addr;
    req.wdata    = e.wdata;
    req_val      = 1'b1;
    cycles       = 0;
    while (!req_rdy && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!req_rdy) begin
      $display("Timeout: the cache never accepted request %0d", n);
      timeout_count++;
      return;
    end
    @(negedge clk);                              // Accepted on the edge just passed
    req_val = 1'b0;
    req     = '0;
    latency = 1;
    while (!resp_val && latency < wait_limit) begin
      @(negedge clk);
      latency++;
    end
    if (!resp_val) begin
      $display("Timeout: no response from the cache for request %0d", n);
      timeout_count++;
      return;
    end
    if (e.exp_hit && latency != 3)
      report_error($sformatf("entry %0d hit response after %0d cycles, not 3", n, latency));
    held = resp;
    hold = $random(seed) & 7;
    for (int i = 0; i <= hold; i++) begin
      if (i > 0) @(negedge clk);
      if (resp_val !== 1'b1) report_error($sformatf("entry %0d resp_val dropped", n));
      if (resp !== held) report_error($sformatf("entry %0d resp changed while held", n));
      if (req_rdy !== 1'b0) report_error($sformatf("entry %0d req_rdy high while busy", n));
    end
    resp_rdy = 1'b1;
    @(negedge clk);
    resp_rdy = 1'b0;
    if (resp_val !== 1'b0 || req_rdy !== 1'b1)
      report_error($sformatf("entry %0d cache not idle after the response", n));
    // Compare against the table
    if (held.resp_type !== e.req_type) report_error($sformatf("entry %0d wrong type", n));
    if (held.hit !== e.exp_hit)
      report_error($sformatf("entry %0d hit %b, expected %b", n, held.hit, e.exp_hit));
    if (e.chk_data && held.rdata !== e.exp_data)
      report_error($sformatf("entry %0d data %h, expected %h", n, held.rdata, e.exp_data));
    if (mem0.write_count != e.exp_wb)
      report_error($sformatf("entry %0d write-backs %0d, expected %0d",
                             n, mem0.write_count, e.exp_wb));
  endtask

  // ==============================
  // Stimulus table and main flow
  // ==============================
  initial begin
    line_t exp_line;
    error_count   = 0;
    timeout_count = 0;
    seed          = 81;
    reset         = 1'b1;
    req_val       = 1'b0;
    req           = '0;
    resp_rdy      = 1'b0;

    // Set 1 with a cold miss, hits in the line and a write hit read back
    add_read(32'h014, 1'b0, fill_word(32'h014), 0);
    add_read(32'h018, 1'b1, fill_word(32'h018), 0);
    add_read(32'h010, 1'b1, fill_word(32'h010), 0);
    add_write(32'h01c, 32'hcafe_0001, 1'b1, 0);
    add_read(32'h01c, 1'b1, 32'hcafe_0001, 0);
    // Set 2 runs A, B, A and C, after which A stays and B is gone
    add_read(32'h024, 1'b0, fill_word(32'h024), 0);
    add_read(32'h0a4, 1'b0, fill_word(32'h0a4), 0);
    add_read(32'h024, 1'b1, fill_word(32'h024), 0);
    add_read(32'h124, 1'b0, fill_word(32'h124), 0);
    add_read(32'h024, 1'b1, fill_word(32'h024), 0);
    add_read(32'h0a4, 1'b0, fill_word(32'h0a4), 0);
    // Set 3 has dirty A pushed out by two newer lines
    add_write(32'h038, 32'h1234_5678, 1'b0, 0);
    add_read(32'h0b0, 1'b0, fill_word(32'h0b0), 0);
    add_read(32'h130, 1'b0, fill_word(32'h130), 1);
    add_read(32'h038, 1'b0, 32'h1234_5678, 1);

    repeat (5) @(negedge clk);
    reset = 1'b0;
    if (req_rdy !== 1'b1 || resp_val !== 1'b0 || mem_req_val !== 1'b0 || mem_resp_rdy !== 1'b0)
      report_error("handshake outputs wrong after reset");
    if (dut0.status0.valid_bits !== '0 || dut0.status0.dirty_bits !== '0 ||
        dut0.status0.lru_bits !== '0)
      report_error("status bits not cleared by reset");

    for (int n = 0; n < entries.size() && timeout_count == 0; n++) begin
      run_entry(n, entries[n]);
    end

    // Written-back line of A holds the store among pattern words
    if (timeout_count == 0) begin
      exp_line = {fill_word(32'h03c), 32'h1234_5678, fill_word(32'h034), fill_word(32'h030)};
      if (mem0.lines[3] !== exp_line) report_error("write-back line at 0x30 wrong");
      if (mem0.last_write_addr !== 32'h030) report_error("write-back went to wrong address");
      if (mem0.range_errors != 0) report_error("memory saw an address out of range");
    end

    $display("Run complete: %0d errors, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: test/mem_model.sv
// Line-wide backing memory for the cache testbench
// Pattern fill, fixed response delay and a count of line writes

`timescale 1ns/1ps

module mem_model #(
  parameter int               num_lines = 256,
  parameter int               delay     = 3,             // Cycles from accept to response
  parameter cache_pkg::word_t fill_key  = 32'h5a3c_96e1
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_val,
  output logic                  req_rdy,
  input  cache_pkg::mem_req_t   req,
  output logic                  resp_val,
  input  logic                  resp_rdy,
  output cache_pkg::mem_resp_t  resp
);
  import cache_pkg::*;

  localparam int line_idx_w = $clog2(num_lines);

  line_t lines [num_lines];
  int    write_count;                  // Line writes since reset
  addr_t last_write_addr;
  int    range_errors;                 // Requests beyond the modelled space
  logic  busy;                         // One request in flight at a time
  int    wait_cnt;
  line_t rd_line;

  assign req_rdy   = !busy;
  assign resp.data = rd_line;

  always @(posedge clk) begin
    if (reset) begin
      // Each word holds its own byte address XOR the key
      for (int i = 0; i < num_lines; i++) begin
        for (int w = 0; w < 4; w++) begin
          lines[i][w*32 +: 32] <= addr_t'(i * 16 + w * 4) ^ fill_key;
        end
      end
      busy            <= 1'b0;
      resp_val        <= 1'b0;
      wait_cnt        <= 0;
      write_count     <= 0;
      last_write_addr <= '0;
      range_errors    <= 0;
      rd_line         <= '0;
    end else if (req_val && req_rdy) begin
      busy     <= 1'b1;
      wait_cnt <= delay;
      if ((req.addr >> 4) >= num_lines) range_errors <= range_errors + 1;
      if (req.mem_type == req_write) begin
        lines[req.addr[4 +: line_idx_w]] <= req.data;
        write_count     <= write_count + 1;
        last_write_addr <= req.addr;
        rd_line         <= req.data;   // Ack echoes the line
      end else begin
        rd_line <= lines[req.addr[4 +: line_idx_w]];
      end
    end else if (busy && !resp_val) begin
      if (wait_cnt <= 1) resp_val <= 1'b1;
      else wait_cnt <= wait_cnt - 1;
    end else if (resp_val && resp_rdy) begin
      resp_val <= 1'b0;                // Response taken, ready again
      busy     <= 1'b0;
    end
  end

endmodule

// File: logic/blocking_cache.sv
// Two-way set-associative blocking data cache, top level
// Connects request capture, status bits, line storage and the controller

`timescale 1ns/1ps

module blocking_cache #(
  parameter int num_sets = 8                      // 8 sets give 256 bytes
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  output logic                    req_rdy,
  input  cache_pkg::cache_req_t   req,
  output logic                    resp_val,
  input  logic                    resp_rdy,
  output cache_pkg::cache_resp_t  resp,
  output logic                    mem_req_val,
  input  logic                    mem_req_rdy,
  output cache_pkg::mem_req_t     mem_req,
  input  logic                    mem_resp_val,
  output logic                    mem_resp_rdy,
  input  cache_pkg::mem_resp_t    mem_resp
);
  import cache_pkg::*;

  localparam int index_w = $clog2(num_sets);

  tag_t cur_tag, tag0, tag1, victim_tag, evict_tag;
  logic [index_w-1:0] cur_index;
  offset_t cur_offset;
  req_type_t cur_type;
  word_t cur_wdata, rdata;
  line_t victim_line, evict_line;
  logic accept, way, hit, hit_way, victim_way, victim_dirty;
  logic valid_wen, valid_wdata, dirty_wen, dirty_wdata, lru_wen;
  logic word_wen, refill_wen, evict_capture, resp_capture;
  logic mem_req_is_write, resp_hit;

  // Victim held for the write-back request
  always_ff @(posedge clk) begin
    if (evict_capture) begin
      evict_tag  <= victim_tag;
      evict_line <= victim_line;
    end
  end

  // Write-back uses the victim address, refill the request address
  assign mem_req.mem_type = mem_req_is_write ? req_write : req_read;
  assign mem_req.addr = {(mem_req_is_write ? evict_tag : cur_tag), {line_off_w{1'b0}}};
  assign mem_req.data = evict_line;

  assign resp.resp_type = cur_type;
  assign resp.hit       = resp_hit;
  assign resp.rdata     = rdata;

  req_decode #(.num_sets(num_sets)) decode0 (.*);

  way_status #(.num_sets(num_sets)) status0 (
    .clk, .reset, .index(cur_index), .lookup_tag(cur_tag), .tag0, .tag1, .way,
    .valid_wen, .valid_wdata, .dirty_wen, .dirty_wdata, .lru_wen,
    .hit, .hit_way, .victim_way, .victim_dirty
  );

  line_store #(.num_sets(num_sets)) store0 (
    .clk, .index(cur_index), .way, .wr_tag(cur_tag), .offset(cur_offset),
    .wdata(cur_wdata), .word_wen, .refill_wen, .refill_line(mem_resp.data),
    .resp_capture, .tag0, .tag1, .victim_tag, .victim_line, .rdata
  );

  cache_ctrl ctrl0 (.*);

endmodule

// File: logic/cache_ctrl.sv
// Controller FSM of the blocking cache
// Sequences tag check, access, write-back, refill and the response

`timescale 1ns/1ps

module cache_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req_val,
  input  cache_pkg::req_type_t  cur_type,
  input  logic                  hit,
  input  logic                  hit_way,
  input  logic                  victim_way,
  input  logic                  victim_dirty,
  input  logic                  resp_rdy,
  input  logic                  mem_req_rdy,
  input  logic                  mem_resp_val,
  output logic                  accept,
  output logic                  way,
  output logic                  valid_wen,
  output logic                  valid_wdata,
  output logic                  dirty_wen,
  output logic                  dirty_wdata,
  output logic                  lru_wen,
  output logic                  word_wen,
  output logic                  refill_wen,
  output logic                  evict_capture,
  output logic                  resp_capture,
  output logic                  resp_val,
  output logic                  mem_req_val,
  output logic                  mem_req_is_write,
  output logic                  mem_resp_rdy,
  output logic                  resp_hit
);
  import cache_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  ctrl_state_t access_state;              // Read or write access for this request

  assign access_state = (cur_type == req_write) ? st_write_access : st_read_access;

  // ==============================
  // State and lookup registers
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      resp_hit <= 1'b0;
      way      <= 1'b0;
    end else begin
      state <= state_next;
      if (state == st_tag_check) begin
        resp_hit <= hit;
        way      <= hit ? hit_way : victim_way;   // Victim way owns the refill
      end
    end
  end

  // ==============================
  // Next state and strobes
  // ==============================
  always_comb begin
    state_next       = state;
    accept           = 1'b0;
    valid_wen        = 1'b0;
    valid_wdata      = 1'b0;
    dirty_wen        = 1'b0;
    dirty_wdata      = 1'b0;
    lru_wen          = 1'b0;
    word_wen         = 1'b0;
    refill_wen       = 1'b0;
    evict_capture    = 1'b0;
    resp_capture     = 1'b0;
    resp_val         = 1'b0;
    mem_req_val      = 1'b0;
    mem_req_is_write = 1'b0;
    mem_resp_rdy     = 1'b0;
    case (state)
      st_idle: begin
        accept = 1'b1;
        if (req_val) state_next = st_tag_check;
      end
      st_tag_check: begin
        if (hit) state_next = access_state;
        else if (victim_dirty) state_next = st_evict_prepare;
        else state_next = st_refill_request;
      end
      st_read_access: begin
        lru_wen      = 1'b1;
        resp_capture = 1'b1;              // Addressed word into the result register
        state_next   = st_resp_wait;
      end
      st_write_access: begin
        word_wen     = 1'b1;
        dirty_wen    = 1'b1;
        dirty_wdata  = 1'b1;              // Line now differs from memory
        lru_wen      = 1'b1;
        resp_capture = 1'b1;
        state_next   = st_resp_wait;
      end
      st_evict_prepare: begin
        evict_capture = 1'b1;             // Latch victim tag and line
        state_next    = st_evict_request;
      end
      st_evict_request: begin
        mem_req_val      = 1'b1;
        mem_req_is_write = 1'b1;
        if (mem_req_rdy) state_next = st_evict_wait;
      end
      st_evict_wait: begin
        mem_resp_rdy = 1'b1;              // Write acknowledge
        if (mem_resp_val) state_next = st_refill_request;
      end
      st_refill_request: begin
        mem_req_val = 1'b1;
        if (mem_req_rdy) begin
          valid_wen  = 1'b1;              // Way is invalid while the line is in flight
          state_next = st_refill_wait;
        end
      end
      st_refill_wait: begin
        mem_resp_rdy = 1'b1;
        refill_wen   = mem_resp_val;      // Line and tag written on the handshake
        if (mem_resp_val) state_next = st_refill_update;
      end
      st_refill_update: begin
        valid_wen   = 1'b1;
        valid_wdata = 1'b1;
        dirty_wen   = 1'b1;               // Fresh line is clean
        state_next  = access_state;       // Replay the access that missed
      end
      st_resp_wait: begin
        resp_val = 1'b1;
        if (resp_rdy) state_next = st_idle;
      end
      default: state_next = st_idle;
    endcase
  end

endmodule

// File: logic/line_store.sv
// Tag and data arrays of both cache ways
// Word writes, line refill, victim read-out and the response data register

`timescale 1ns/1ps

module line_store #(
  parameter int num_sets = 8
) (
  input  logic                          clk,
  input  logic [$clog2(num_sets)-1:0]   index,
  input  logic                          way,
  input  cache_pkg::tag_t               wr_tag,       // Tag written with a refill
  input  cache_pkg::offset_t            offset,
  input  cache_pkg::word_t              wdata,
  input  logic                          word_wen,
  input  logic                          refill_wen,
  input  cache_pkg::line_t              refill_line,
  input  logic                          resp_capture,
  output cache_pkg::tag_t               tag0,
  output cache_pkg::tag_t               tag1,
  output cache_pkg::tag_t               victim_tag,
  output cache_pkg::line_t              victim_line,
  output cache_pkg::word_t              rdata
);
  import cache_pkg::*;

  // ==============================
  // Storage
  // ==============================
  tag_t  tag_mem  [2][num_sets];
  line_t data_mem [2][num_sets];

  line_t sel_line;                        // Line of the selected way
  logic [6:0] word_bit;                   // Bit position of the addressed word

  assign sel_line = data_mem[way][index];
  assign word_bit = {offset, 5'd0};

  // Combinational reads
  assign tag0        = tag_mem[0][index];
  assign tag1        = tag_mem[1][index];
  assign victim_tag  = tag_mem[way][index];
  assign victim_line = sel_line;

  // Refill replaces the line and tag, a store touches one word
  always_ff @(posedge clk) begin
    if (refill_wen) begin
      data_mem[way][index] <= refill_line;
      tag_mem[way][index]  <= wr_tag;
    end else if (word_wen) begin
      data_mem[way][index][word_bit +: word_w] <= wdata;
    end
  end

  // Result stage, holds the word until the next access
  always_ff @(posedge clk) begin
    if (resp_capture) begin
      rdata <= sel_line[word_bit +: word_w];
    end
  end

endmodule

// File: logic/way_status.sv
// Per-set status bits of the two-way cache
// Valid, dirty and LRU state plus hit detection and victim choice

`timescale 1ns/1ps

module way_status #(
  parameter int num_sets = 8
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [$clog2(num_sets)-1:0]   index,
  input  cache_pkg::tag_t               lookup_tag,   // Tag of the current request
  input  cache_pkg::tag_t               tag0,         // Stored tag, way 0
  input  cache_pkg::tag_t               tag1,         // Stored tag, way 1
  input  logic                          way,          // Way targeted by bit writes
  input  logic                          valid_wen,
  input  logic                          valid_wdata,
  input  logic                          dirty_wen,
  input  logic                          dirty_wdata,
  input  logic                          lru_wen,
  output logic                          hit,
  output logic                          hit_way,
  output logic                          victim_way,
  output logic                          victim_dirty
);

  // ==============================
  // Status arrays
  // ==============================
  logic [num_sets-1:0][1:0] valid_bits;   // [set][way]
  logic [num_sets-1:0][1:0] dirty_bits;   // [set][way]
  logic [num_sets-1:0]      lru_bits;     // Names the least recently used way

  logic hit0;
  logic hit1;

  // Tag compare on both ways at once
  assign hit0 = valid_bits[index][0] && (tag0 == lookup_tag);
  assign hit1 = valid_bits[index][1] && (tag1 == lookup_tag);

  assign hit          = hit0 || hit1;
  assign hit_way      = !hit0 && hit1;                  // Way 0 wins a tie
  assign victim_way   = lru_bits[index];
  assign victim_dirty = dirty_bits[index][victim_way];  // Needs write-back when set

  // ==============================
  // Bit updates
  // ==============================
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
      lru_bits   <= '0;
    end else begin
      if (valid_wen) begin
        valid_bits[index][way] <= valid_wdata;
      end
      if (dirty_wen) begin
        dirty_bits[index][way] <= dirty_wdata;
      end
      if (lru_wen) begin
        lru_bits[index] <= ~way;          // The way not just used becomes LRU
      end
    end
  end

endmodule

// File: logic/req_decode.sv
// Request capture for the blocking cache
// Registers an accepted request and splits its address into tag, set and word

`timescale 1ns/1ps

module req_decode #(
  parameter int num_sets = 8
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          req_val,
  input  cache_pkg::cache_req_t         req,
  input  logic                          accept,      // High while the FSM sits in idle
  output logic                          req_rdy,
  output cache_pkg::tag_t               cur_tag,
  output logic [$clog2(num_sets)-1:0]   cur_index,
  output cache_pkg::offset_t            cur_offset,
  output cache_pkg::req_type_t          cur_type,
  output cache_pkg::word_t              cur_wdata
);
  import cache_pkg::*;

  localparam int index_w = $clog2(num_sets);

  logic take;                                         // Handshake on the processor side

  assign req_rdy = accept;
  assign take    = req_val && accept;

  // Address split, tag keeps all bits above the line offset
  always_ff @(posedge clk) begin
    if (take) begin
      cur_tag    <= req.addr[addr_w-1:line_off_w];
      cur_index  <= req.addr[line_off_w +: index_w];
      cur_offset <= req.addr[3:2];
      cur_wdata  <= req.wdata;
    end
  end

  // Type steers the FSM branches
  always_ff @(posedge clk) begin
    if (reset) begin
      cur_type <= req_read;
    end else if (take) begin
      cur_type <= req.req_type;
    end
  end

endmodule

// File: logic/cache_pkg.sv
// Shared types for the two-way blocking data cache
// Widths, request and response structs, controller state encoding

package cache_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int addr_w     = 32;
  localparam int word_w     = 32;
  localparam int line_w     = 128;          // Four words per line
  localparam int line_off_w = 4;            // Byte offset inside a line
  localparam int tag_w      = addr_w - line_off_w;  // Tag ignores the set count

  typedef logic [addr_w-1:0] addr_t;        // Byte address
  typedef logic [word_w-1:0] word_t;        // Data word
  typedef logic [line_w-1:0] line_t;        // Full cache line
  typedef logic [tag_w-1:0]  tag_t;         // Address bits above the line offset
  typedef logic [1:0]        offset_t;      // Word select, address bits 3:2

  typedef enum logic {
    req_read  = 1'b0,
    req_write = 1'b1
  } req_type_t;

  // ==============================
  // Port payloads
  // ==============================
  typedef struct packed {
    req_type_t req_type;
    addr_t     addr;
    word_t     wdata;                       // Ignored on reads
  } cache_req_t;                            // 65 bits

  typedef struct packed {
    req_type_t resp_type;
    logic      hit;
    word_t     rdata;
  } cache_resp_t;                           // 34 bits

  typedef struct packed {
    req_type_t mem_type;                    // Write means victim write-back
    addr_t     addr;                        // Always line aligned
    line_t     data;
  } mem_req_t;                              // 161 bits

  typedef struct packed {
    line_t data;
  } mem_resp_t;                             // 128 bits

  // Controller FSM, one state per cycle class
  typedef enum logic [3:0] {
    st_idle, st_tag_check, st_read_access, st_write_access,
    st_evict_prepare, st_evict_request, st_evict_wait,
    st_refill_request, st_refill_wait, st_refill_update, st_resp_wait
  } ctrl_state_t;

endpackage
